//--- Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_la_frontend
RTL_TOP   ?= la_frontend_top
FILELIST  ?= la_frontend.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timescale $(TIMESCALE) --top-module $(RTL_TOP) \
		common/la_frontend_pkg.sv frontend/pc_gen.sv frontend/fetch_stage.sv \
		frontend/predecode_stage.sv rtl/la_frontend_top.sv

clean:
	rm -rf $(BUILD_DIR)

//--- bench/imem_model.sv
`default_nettype none

module imem_model (
    input  logic                        clk,
    input  logic                        i_req,
    input  la_frontend_pkg::addr_t      i_addr,
    output la_frontend_pkg::inst_pair_t o_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    import la_frontend_pkg::*;

    localparam int AW    = 10;
    localparam int WORDS = 1 << AW;

    // loaded by the testbench before reset ends
    inst_t mem [0:WORDS-1];

    function automatic logic [AW-1:0] word_idx(addr_t a);
        return a[AW+1:2];  // 4 KiB window, higher bits alias
    endfunction

    // one-cycle read, last pair stays put while no request
    always @(posedge clk) begin
        if (i_req) begin
            o_rdata <= {mem[word_idx(i_addr + 32'd4)], mem[word_idx(i_addr)]};
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_la_frontend.sv
`default_nettype none

module tb_la_frontend;
    timeunit 1ns;
    timeprecision 100ps;

    import la_frontend_pkg::*;

    localparam int    CLK_PERIOD   = 100;
    localparam int    RST_CYCLES   = 16;
    localparam int    IMEM_WORDS   = 1024;
    localparam int    TEST_CYCLES  = RST_CYCLES + 20 + 40 + 204 + 28 + 30;
    localparam int    MARGIN       = 100;
    localparam addr_t BR1_PC       = 32'h1c00_0100;  // b in slot 1
    localparam addr_t BR2_PAIR_PC  = 32'h1c00_0150;  // bl in slot 2

    logic        clk;
    logic        i_arst_n;
    logic        i_br_redirect;
    logic        i_exc_redirect;
    logic        i_issue_stall;
    addr_t       i_br_pc;
    addr_t       i_exc_pc;
    inst_pair_t  imem_rdata;
    logic        imem_req;
    addr_t       imem_addr;
    slot_valid_t o_issue_valid;
    logic        o_issue_adef;
    addr_t       o_issue_pc1;
    addr_t       o_issue_pc2;
    inst_t       o_issue_ir1;
    inst_t       o_issue_ir2;

    inst_t  image [0:IMEM_WORDS-1];
    integer seed;
    int     errors;
    int     fails;
    int     issued;
    int     adef_seen;
    int     br1_hits;
    int     br2_hits;
    addr_t  exp_pc;
    logic   quiet;     // fetch expected parked after adef
    addr_t  watch_pc;
    logic   watch_hit;
    addr_t  held_addr; // imem address at the last stalled edge
    logic   held_prev;

    la_frontend_top i_dut (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_br_redirect  (i_br_redirect),
        .i_exc_redirect (i_exc_redirect),
        .i_issue_stall  (i_issue_stall),
        .i_br_pc        (i_br_pc),
        .i_exc_pc       (i_exc_pc),
        .i_imem_rdata   (imem_rdata),
        .o_imem_req     (imem_req),
        .o_imem_addr    (imem_addr),
        .o_issue_valid  (o_issue_valid),
        .o_issue_adef   (o_issue_adef),
        .o_issue_pc1    (o_issue_pc1),
        .o_issue_pc2    (o_issue_pc2),
        .o_issue_ir1    (o_issue_ir1),
        .o_issue_ir2    (o_issue_ir2)
    );

    imem_model i_imem (
        .clk     (clk),
        .i_req   (imem_req),
        .i_addr  (imem_addr),
        .o_rdata (imem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + MARGIN * CLK_PERIOD);
        $display("watchdog expired, the tests did not complete in time");
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [9:0] word_idx(addr_t a);
        return a[11:2];
    endfunction

    function automatic inst_t encode_branch(logic [5:0] opc, logic [25:0] offs);
        return {opc, offs[15:0], offs[25:16]};
    endfunction

    function automatic addr_t branch_dest(addr_t pc, inst_t ir);
        logic [25:0] offs;
        offs = {ir[9:0], ir[25:10]};
        return pc + {{4{offs[25]}}, offs, 2'b00};
    endfunction

    // predecode rule applied to the image
    function automatic void expected_pair(input addr_t pc, output slot_valid_t v,
                                          output inst_t ir1, output inst_t ir2,
                                          output addr_t nxt);
        logic b1;
        logic b2;
        ir1 = image[word_idx(pc)];
        ir2 = image[word_idx(pc + 32'd4)];
        b1  = (ir1[31:26] == OPC_B) || (ir1[31:26] == OPC_BL);
        b2  = (ir2[31:26] == OPC_B) || (ir2[31:26] == OPC_BL);
        if (pc[1:0] != 2'b00) begin
            v   = 2'b10;
            ir1 = '0;
            ir2 = '0;
            nxt = pc;
        end else if (b1) begin
            v   = 2'b10;
            nxt = branch_dest(pc, ir1);
        end else if (b2) begin
            v   = 2'b11;
            nxt = branch_dest(pc + 32'd4, ir2);
        end else begin
            v   = 2'b11;
            nxt = pc + 32'd8;
        end
    endfunction

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_inst(input string what, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_valid(input string what, input slot_valid_t got,
                               input slot_valid_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin : compare_proc
        slot_valid_t ev;
        inst_t       e1;
        inst_t       e2;
        addr_t       en;
        if (i_arst_n) begin
            if (held_prev) begin
                check_addr("imem addr under stall", imem_addr, held_addr);
            end
            if (imem_addr[1:0] != 2'b00) begin
                check_flag("imem req on misaligned pc", imem_req, 1'b0);
            end
            if (quiet) begin
                check_flag("imem req while halted", imem_req, 1'b0);
            end
        end
        held_prev = i_arst_n && i_issue_stall && !i_br_redirect && !i_exc_redirect;
        held_addr = imem_addr;
        if (i_arst_n && !i_issue_stall && o_issue_valid != 2'b00) begin
            expected_pair(exp_pc, ev, e1, e2, en);
            issued++;
            if (quiet) begin
                errors++;
                $display("a pair at %h was issued while fetch should be halted", o_issue_pc1);
            end
            check_addr("pc1", o_issue_pc1, exp_pc);
            check_addr("pc2", o_issue_pc2, exp_pc + 32'd4);
            check_inst("ir1", o_issue_ir1, e1);
            check_inst("ir2", o_issue_ir2, e2);
            check_valid("slot valid", o_issue_valid, ev);
            check_flag("adef", o_issue_adef, exp_pc[1:0] != 2'b00);
            if (o_issue_pc1 == watch_pc) begin
                watch_hit = 1'b1;
            end
            if (exp_pc[1:0] != 2'b00) begin
                adef_seen++;
                quiet = 1'b1;
            end else if (ev == 2'b10) begin
                br1_hits++;
            end else if (en != exp_pc + 32'd8) begin
                br2_hits++;
            end
            exp_pc = en;
        end
        if (i_exc_redirect) begin
            exp_pc = i_exc_pc;
            quiet  = 1'b0;
        end else if (i_br_redirect) begin
            exp_pc = i_br_pc;
            quiet  = 1'b0;
        end
    end

    task automatic redirect(input logic br, input logic exc, input addr_t bpc, input addr_t epc);
        @(negedge clk);
        i_br_redirect  = br;
        i_exc_redirect = exc;
        i_br_pc        = bpc;
        i_exc_pc       = epc;
        @(negedge clk);
        i_br_redirect  = 1'b0;
        i_exc_redirect = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int err_before,
                               input logic cond_ok);
        if (errors == err_before && cond_ok) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            fails++;
            $display("test %0d %s: failed", num, name);
        end
    endtask

    initial begin : stimulus
        int    e0;
        int    n0;
        inst_t w;
        logic  adef_ok;
        seed           = 32'hae55b804;
        errors         = 0;
        fails          = 0;
        issued         = 0;
        adef_seen      = 0;
        br1_hits       = 0;
        br2_hits       = 0;
        exp_pc         = PC_RESET;
        quiet          = 1'b0;
        watch_pc       = '1;
        watch_hit      = 1'b0;
        held_addr      = '0;
        held_prev      = 1'b0;
        i_arst_n       = 1'b0;
        i_br_redirect  = 1'b0;
        i_exc_redirect = 1'b0;
        i_issue_stall  = 1'b0;
        i_br_pc        = '0;
        i_exc_pc       = '0;

        for (int k = 0; k < IMEM_WORDS; k++) begin
            w = $random(seed);
            if (w[31:26] == OPC_B || w[31:26] == OPC_BL) begin
                w[31] = ~w[31];  // only planted branches
            end
            image[k] = w;
        end
        image[word_idx(BR1_PC)]             = encode_branch(OPC_B, 26'd16);
        image[word_idx(BR2_PAIR_PC + 32'd4)] = encode_branch(OPC_BL, 26'd11);
        for (int k = 0; k < IMEM_WORDS; k++) begin
            i_imem.mem[k] = image[k];
        end

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;

        e0 = errors;
        check_flag("imem req after reset", imem_req, 1'b1);
        check_addr("imem addr after reset", imem_addr, PC_RESET);
        repeat (20) @(negedge clk);
        report_test(1, "sequential stream", e0, issued > 10);

        e0 = errors;
        repeat (40) @(negedge clk);
        report_test(2, "predecode branches", e0, br1_hits > 0 && br2_hits > 0);

        e0 = errors;
        n0 = issued;
        repeat (200) begin
            @(negedge clk);
            w = $random(seed);
            if (w[1:0] == 2'b00) begin
                i_issue_stall = ~i_issue_stall;
            end
        end
        i_issue_stall = 1'b0;
        repeat (4) @(negedge clk);
        report_test(3, "issue stalls", e0, issued - n0 > 20);

        e0 = errors;
        watch_hit = 1'b0;
        watch_pc  = 32'h1c00_0200;
        redirect(1'b1, 1'b0, watch_pc, '0);
        repeat (10) @(negedge clk);
        if (!watch_hit) begin
            $display("no pair issued at the execute redirect target");
        end
        n0 = watch_hit;
        watch_hit = 1'b0;
        watch_pc  = 32'h1c00_0400;
        redirect(1'b1, 1'b1, 32'h1c00_0300, watch_pc);
        repeat (10) @(negedge clk);
        if (!watch_hit) begin
            $display("no pair issued at the exception redirect target");
        end
        report_test(4, "external redirects", e0, n0 != 0 && watch_hit);

        e0 = errors;
        adef_seen = 0;
        redirect(1'b1, 1'b0, 32'h1c00_0502, '0);
        n0 = issued;
        repeat (12) @(negedge clk);
        if (adef_seen != 1 || issued - n0 != 1) begin
            $display("misaligned fetch gave %0d pairs, %0d with adef", issued - n0, adef_seen);
        end
        adef_ok = adef_seen == 1 && issued - n0 == 1;
        redirect(1'b1, 1'b0, PC_RESET, '0);
        n0 = issued;
        repeat (10) @(negedge clk);
        report_test(5, "fetch address error", e0, adef_ok && issued > n0);

        $display("tests failed %0d of 5, value errors %0d, pairs checked %0d",
                 fails, errors, issued);
        if (fails == 0 && errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- common/la_frontend_pkg.sv
`default_nettype none

package la_frontend_pkg;

    localparam int XLEN       = 32;
    localparam int INST_BYTES = XLEN / 8;
    localparam int OFFS_W     = 26;  // b/bl offset field, in words
    localparam int OFFS_SHIFT = 2;

    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [XLEN-1:0]   inst_t;
    typedef logic [2*XLEN-1:0] inst_pair_t;  // slot 1 low word, slot 2 high word
    typedef logic [1:0]        slot_valid_t; // bit 1 is slot 1

    localparam addr_t PC_RESET     = 32'h1c00_0000;
    localparam addr_t FETCH_STRIDE = 32'd8;

    localparam logic [5:0] OPC_B  = 6'b010100;
    localparam logic [5:0] OPC_BL = 6'b010101;

    // direct b / bl only
    function automatic logic is_dir_branch(inst_t ir);
        logic [5:0] opc;
        opc = ir[31:26];
        return (opc == OPC_B) || (opc == OPC_BL);
    endfunction

    // offs26 is split over the word, ir[9:0] holds the upper bits
    function automatic addr_t branch_target(addr_t pc, inst_t ir);
        logic [OFFS_W-1:0] offs;
        addr_t             offs_ext;
        offs     = {ir[9:0], ir[25:10]};
        offs_ext = {{(XLEN-OFFS_W){offs[OFFS_W-1]}}, offs};
        return pc + (offs_ext << OFFS_SHIFT);
    endfunction

endpackage

`default_nettype wire

//--- frontend/fetch_stage.sv
`default_nettype none

module fetch_stage (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_hold,
    input  logic                   i_flush,
    input  logic                   i_fetch_valid,
    input  logic                   i_fetch_adef,
    input  la_frontend_pkg::addr_t i_fetch_pc,
    output logic                   o_valid,
    output logic                   o_adef,
    output la_frontend_pkg::addr_t o_pc
);
    import la_frontend_pkg::*;

    logic  valid_q;
    logic  adef_q;
    addr_t pc_q;

    // lines up with the read data that arrives one cycle later
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;
        end else if (!i_hold) begin
            valid_q <= i_fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            pc_q   <= i_fetch_pc;
            adef_q <= i_fetch_adef;
        end
    end

    assign o_valid = valid_q;
    assign o_adef  = adef_q;
    assign o_pc    = pc_q;

endmodule

`default_nettype wire

//--- frontend/pc_gen.sv
`default_nettype none

module pc_gen (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_hold,
    input  logic                   i_flush_exc,
    input  logic                   i_flush_br,
    input  logic                   i_pre_redirect,
    input  la_frontend_pkg::addr_t i_exc_pc,
    input  la_frontend_pkg::addr_t i_br_pc,
    input  la_frontend_pkg::addr_t i_pre_pc,
    output logic                   o_imem_req,
    output logic                   o_fetch_valid,
    output logic                   o_fetch_adef,
    output la_frontend_pkg::addr_t o_imem_addr
);
    import la_frontend_pkg::*;

    addr_t pc_q;
    addr_t pc_d;
    logic  halted_q;
    logic  halted_d;
    logic  misaligned;

    assign misaligned = |pc_q[OFFS_SHIFT-1:0];

    // external redirects act even under hold
    always_comb begin
        pc_d     = pc_q;
        halted_d = halted_q;
        if (i_flush_exc) begin
            pc_d     = i_exc_pc;
            halted_d = 1'b0;
        end else if (i_flush_br) begin
            pc_d     = i_br_pc;
            halted_d = 1'b0;
        end else if (!i_hold) begin
            if (i_pre_redirect) begin
                pc_d = i_pre_pc;
            end else if (halted_q || misaligned) begin
                halted_d = 1'b1;  // park until an external redirect
            end else begin
                pc_d = pc_q + FETCH_STRIDE;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q     <= PC_RESET;
            halted_q <= 1'b0;
        end else begin
            pc_q     <= pc_d;
            halted_q <= halted_d;
        end
    end

    // no read while held, so the memory keeps its last word pair
    assign o_imem_req    = ~halted_q & ~misaligned & ~i_hold;
    assign o_imem_addr   = pc_q;
    assign o_fetch_valid = ~halted_q;
    assign o_fetch_adef  = misaligned;

endmodule

`default_nettype wire

//--- frontend/predecode_stage.sv
`default_nettype none

module predecode_stage (
    input  logic                          clk,
    input  logic                          i_arst_n,
    input  logic                          i_hold,
    input  logic                          i_flush,
    input  logic                          i_valid,
    input  logic                          i_adef,
    input  la_frontend_pkg::addr_t        i_pc,
    input  la_frontend_pkg::inst_pair_t   i_pair,
    output logic                          o_redirect,
    output la_frontend_pkg::addr_t        o_redirect_pc,
    output la_frontend_pkg::slot_valid_t  o_issue_valid,
    output logic                          o_issue_adef,
    output la_frontend_pkg::addr_t        o_issue_pc1,
    output la_frontend_pkg::addr_t        o_issue_pc2,
    output la_frontend_pkg::inst_t        o_issue_ir1,
    output la_frontend_pkg::inst_t        o_issue_ir2
);
    import la_frontend_pkg::*;

    inst_t       ir1;
    inst_t       ir2;
    addr_t       pc2;
    addr_t       tgt1;
    addr_t       tgt2;
    logic        br1;
    logic        br2;
    slot_valid_t slot_valid;

    slot_valid_t valid_q;
    logic        adef_q;
    addr_t       pc1_q;
    addr_t       pc2_q;
    inst_t       ir1_q;
    inst_t       ir2_q;

    // fetch fault carries no instruction bits
    assign ir1 = i_adef ? '0 : i_pair[XLEN-1:0];
    assign ir2 = i_adef ? '0 : i_pair[2*XLEN-1:XLEN];
    assign pc2 = i_pc + INST_BYTES;

    assign br1  = is_dir_branch(ir1);
    assign br2  = is_dir_branch(ir2);
    assign tgt1 = branch_target(i_pc, ir1);
    assign tgt2 = branch_target(pc2, ir2);

    // a taken slot 1 kills slot 2
    always_comb begin
        if (!i_valid) begin
            slot_valid = 2'b00;
        end else if (i_adef || br1) begin
            slot_valid = 2'b10;
        end else begin
            slot_valid = 2'b11;
        end
    end

    assign o_redirect    = i_valid & ~i_adef & ~i_hold & (br1 | br2);
    assign o_redirect_pc = br1 ? tgt1 : tgt2;  // slot 1 first

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 2'b00;
        end else if (i_flush) begin
            valid_q <= 2'b00;
        end else if (!i_hold) begin
            valid_q <= slot_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            adef_q <= i_adef;
            pc1_q  <= i_pc;
            pc2_q  <= pc2;
            ir1_q  <= ir1;
            ir2_q  <= ir2;
        end
    end

    assign o_issue_valid = valid_q;
    assign o_issue_adef  = adef_q;
    assign o_issue_pc1   = pc1_q;
    assign o_issue_pc2   = pc2_q;
    assign o_issue_ir1   = ir1_q;
    assign o_issue_ir2   = ir2_q;

endmodule

`default_nettype wire

//--- la_frontend.f
common/la_frontend_pkg.sv
frontend/pc_gen.sv
frontend/fetch_stage.sv
frontend/predecode_stage.sv
rtl/la_frontend_top.sv
bench/imem_model.sv
bench/tb_la_frontend.sv

//--- rtl/la_frontend_top.sv
`default_nettype none

module la_frontend_top (
    input  logic                          clk,
    input  logic                          i_arst_n,
    input  logic                          i_br_redirect,
    input  logic                          i_exc_redirect,
    input  logic                          i_issue_stall,
    input  la_frontend_pkg::addr_t        i_br_pc,
    input  la_frontend_pkg::addr_t        i_exc_pc,
    input  la_frontend_pkg::inst_pair_t   i_imem_rdata,
    output logic                          o_imem_req,
    output la_frontend_pkg::addr_t        o_imem_addr,
    output la_frontend_pkg::slot_valid_t  o_issue_valid,
    output logic                          o_issue_adef,
    output la_frontend_pkg::addr_t        o_issue_pc1,
    output la_frontend_pkg::addr_t        o_issue_pc2,
    output la_frontend_pkg::inst_t        o_issue_ir1,
    output la_frontend_pkg::inst_t        o_issue_ir2
);
    import la_frontend_pkg::*;

    logic  ext_flush;
    logic  hold;
    logic  fetch_valid;
    logic  fetch_adef;
    logic  if2_valid;
    logic  if2_adef;
    addr_t if2_pc;
    logic  pre_redirect;
    addr_t pre_redirect_pc;

    assign ext_flush = i_br_redirect | i_exc_redirect;
    assign hold      = i_issue_stall;

    pc_gen u_pc_gen (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_hold         (hold),
        .i_flush_exc    (i_exc_redirect),
        .i_flush_br     (i_br_redirect),
        .i_pre_redirect (pre_redirect),
        .i_exc_pc       (i_exc_pc),
        .i_br_pc        (i_br_pc),
        .i_pre_pc       (pre_redirect_pc),
        .o_imem_req     (o_imem_req),
        .o_fetch_valid  (fetch_valid),
        .o_fetch_adef   (fetch_adef),
        .o_imem_addr    (o_imem_addr)
    );

    // predecode redirect drops only the pair behind it
    fetch_stage u_fetch_stage (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_hold        (hold),
        .i_flush       (ext_flush | pre_redirect),
        .i_fetch_valid (fetch_valid),
        .i_fetch_adef  (fetch_adef),
        .i_fetch_pc    (o_imem_addr),
        .o_valid       (if2_valid),
        .o_adef        (if2_adef),
        .o_pc          (if2_pc)
    );

    predecode_stage u_predecode_stage (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_hold        (hold),
        .i_flush       (ext_flush),
        .i_valid       (if2_valid),
        .i_adef        (if2_adef),
        .i_pc          (if2_pc),
        .i_pair        (i_imem_rdata),
        .o_redirect    (pre_redirect),
        .o_redirect_pc (pre_redirect_pc),
        .o_issue_valid (o_issue_valid),
        .o_issue_adef  (o_issue_adef),
        .o_issue_pc1   (o_issue_pc1),
        .o_issue_pc2   (o_issue_pc2),
        .o_issue_ir1   (o_issue_ir1),
        .o_issue_ir2   (o_issue_ir2)
    );

endmodule

`default_nettype wire
